//--- files.f
hw/ahci_dma_pkg.sv
hw/ahci_dma_cfg.sv
hw/ahci_dma_ctl.sv
hw/ahci_dma_ar.sv
hw/ahci_dma_rd_fifo.sv
hw/ahci_dma.sv
testbench/tb_ahci_dma_check.sv
testbench/ahci_dma_assert.sv
testbench/tb_ahci_dma.sv

//--- Makefile
SIM := obj_dir/Vtb_ahci_dma
SRCS := $(wildcard hw/*.sv testbench/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): files.f $(SRCS)
	verilator --binary --timing --assert -f files.f \
		--top-module tb_ahci_dma -o Vtb_ahci_dma

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_ahci_dma.sv
// AHCI DMA testbench top
// random commands against a sparse AXI read memory model, LCG driven
`timescale 1ns/100ps

module tb_ahci_dma
    import ahci_dma_pkg::*;
();

    logic hclk = 1'b0;
    logic hrst = 1'b1;
    logic cmd_start = 1'b0, ct_re = 1'b0, sys_re = 1'b0, cache_we = 1'b0;
    addr_t ctba = '0;
    prd_count_t prdtl = '0;
    ct_index_t ct_addr = '0;
    cache_t cache_wr_data = '0;
    logic arready = 1'b0, rvalid = 1'b0, rlast = 1'b0;
    qword_t rdata = '0;
    axi_id_t rid = '0;
    dword_t ct_data, sys_out;
    logic ct_busy, cmd_busy, cmd_done, prd_done, prd_irq, sys_dav, arvalid, rready;
    addr_t araddr;
    burst_len_t arlen;
    axi_id_t arid;
    cache_t arcache;
    logic [2:0] arsize;
    logic [1:0] arburst;
    int tb_errors = 0;
    int errors;
    logic report = 1'b0;
    logic [31:0] seed = 32'h96fd3090;       // command and memory stream
    logic [31:0] bus_seed = 32'h96fd3090;   // slave and host timing stream
    qword_t mem [addr_t];              // written words, keyed by byte address
    addr_t rq_addr [$];                // accepted AR requests
    burst_len_t rq_len [$];
    axi_id_t rq_id [$];
    logic r_taken = 1'b0;
    int beat = 0;
    int stall = 0;

    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_next();
        seed = lcg_step(seed);
        return seed ^ (seed >> 16);
    endfunction

    function automatic logic [31:0] bus_rand();
        bus_seed = lcg_step(bus_seed);
        return bus_seed ^ (bus_seed >> 16);
    endfunction

    function automatic qword_t mem_read(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a ^ 32'hc3a5_1e0f, ~a ^ {a[15:0], a[31:16]}};  // unwritten fill
    endfunction

    always #4 hclk = ~hclk;

    ahci_dma ahci_dma_i (.*);

    tb_ahci_dma_check check_i (.*);

    always @(posedge hclk) begin
        r_taken <= rvalid && rready;
        if (!hrst && arvalid && arready) begin
            rq_addr.push_back(araddr);
            rq_len.push_back(arlen);
            rq_id.push_back(arid);
        end
    end

    // AXI read slave and sys_re pattern
    always @(negedge hclk) begin
        if (hrst) begin
            arready = 1'b0;
            rvalid  = 1'b0;
            rlast   = 1'b0;
            beat    = 0;
        end else begin
            if (r_taken) begin
                rvalid = 1'b0;
                if (rlast) begin
                    rlast = 1'b0;
                    beat  = 0;
                    void'(rq_addr.pop_front());
                    void'(rq_len.pop_front());
                    void'(rq_id.pop_front());
                end else begin
                    beat++;
                end
            end
            if (!rvalid && rq_addr.size() != 0 && bus_rand() % 3 != 0) begin
                rdata  = mem_read(rq_addr[0] + 32'(beat * 8));
                rid    = rq_id[0];
                rlast  = (beat == int'(rq_len[0]));
                rvalid = 1'b1;
            end
            arready = (bus_rand() % 4) != 0;
            if (stall != 0) begin
                stall--;
                sys_re = 1'b0;                          // long host stall
            end else begin
                sys_re = (bus_rand() % 4) != 0;
                if (bus_rand() % 64 == 0) begin
                    stall = 40 + int'(bus_rand() % 160);
                end
            end
        end
    end

    task automatic set_cache();
        logic [31:0] r;
        r = rand_next();
        if (r[1:0] == 2'd0) begin
            @(negedge hclk);
            cache_wr_data = r[7:4];
            cache_we = 1'b1;
            check_i.exp_cache = r[7:4];
            @(negedge hclk);
            cache_we = 1'b0;
        end
    endtask

    task automatic run_command(int cmd);
        addr_t ct_base, prd_a, dptr;
        int nprd, nqw, rem, blen, n;
        logic [31:0] r, r2, dw3;
        qword_t q;
        r = rand_next();
        ct_base = {4'h1, r[27:7], 7'd0};
        for (int i = 0; i < 16; i++) begin
            q = {rand_next(), rand_next()};
            mem[ct_base + 32'(8 * i)] = q;
            check_i.exp_ct[2 * i] = q[31:0];
            check_i.exp_ct[2 * i + 1] = q[63:32];
        end
        check_i.exp_ar.push_back({ct_base, CT_BURST_LEN, ID_CT});
        nprd = int'(rand_next() % 5);
        for (int p = 0; p < nprd; p++) begin
            r = rand_next();
            r2 = rand_next();
            nqw = 1 + int'(r % 40);
            dptr = {8'h20, r2[23:3], 3'b000};
            dw3 = {r[31:22], 22'(8 * (nqw - 1) + int'(r2[26:24]))};   // low 3 bits ignored
            prd_a = ct_base + PRDT_OFFSET + 32'(16 * p);
            mem[prd_a] = {rand_next(), dptr[31:3], r2[2:0]};
            mem[prd_a + 32'd8] = {dw3, rand_next()};
            check_i.exp_ar.push_back({prd_a, PRD_BURST_LEN, ID_PRD});
            rem = nqw;
            for (addr_t a = dptr; rem > 0; a += 32'd128) begin
                blen = (rem > 16) ? 16 : rem;
                check_i.exp_ar.push_back({a, burst_len_t'(blen - 1), ID_DATA});
                rem -= blen;
            end
            for (int k = 0; k < nqw; k++) begin
                q = mem_read(dptr + 32'(8 * k));
                check_i.exp_data.push_back(q[31:0]);    // low dword first
                check_i.exp_data.push_back(q[63:32]);
            end
            check_i.exp_irq.push_back(dw3[PRD_IRQ_BIT]);
        end
        check_i.exp_cmds++;
        @(negedge hclk);
        ctba = ct_base | {25'd0, r[6:0]};               // low bits ignored
        prdtl = prd_count_t'(nprd);
        cmd_start = 1'b1;
        @(negedge hclk);
        cmd_start = 1'b0;
        n = 0;
        do begin
            @(negedge hclk);
            n++;
        end while (!cmd_done && n < 20000);
        if (!cmd_done) begin
            tb_errors++;
            $display("timeout waiting for cmd_done of command %0d", cmd);
        end
        for (int i = 0; i < 32; i++) begin
            ct_re = 1'b1;
            ct_addr = ct_index_t'(i);
            @(negedge hclk);
        end
        ct_re = 1'b0;
        @(negedge hclk);
    endtask

    initial begin
        check_i.exp_cache = CACHE_DEFAULT;
        repeat (5) @(posedge hclk);
        @(negedge hclk);
        hrst = 1'b0;
        for (int cmd = 0; cmd < 12; cmd++) begin
            if (cmd != 0) begin
                set_cache();                            // first command runs on reset value
            end
            run_command(cmd);
        end
        @(negedge hclk);
        report = 1'b1;
        @(negedge hclk);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/ahci_dma_assert.sv
// AHCI DMA handshake assertions
// bound into the top to watch the AR channel and cmd_done
`timescale 1ns/100ps

module ahci_dma_assert
    import ahci_dma_pkg::*;
(
    input logic       hclk,
    input logic       hrst,
    input logic       arvalid,
    input logic       arready,
    input addr_t      araddr,
    input burst_len_t arlen,
    input axi_id_t    arid,
    input logic       cmd_done
);

    // request and payload held while the slave stalls
    assert property (@(posedge hclk) disable iff (hrst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen) && $stable(arid))
        else $error("arvalid or its payload changed before arready");

    assert property (@(posedge hclk) hrst |=> !arvalid)
        else $error("arvalid high right after reset");

    assert property (@(posedge hclk) disable iff (hrst) cmd_done |=> !cmd_done)
        else $error("cmd_done longer than one cycle");

endmodule

bind ahci_dma ahci_dma_assert ahci_dma_assert_i (
    .hclk(hclk), .hrst(hrst), .arvalid(arvalid), .arready(arready),
    .araddr(araddr), .arlen(arlen), .arid(arid), .cmd_done(cmd_done)
);

//--- testbench/tb_ahci_dma_check.sv
// AHCI DMA testbench checker
// compares AR requests, sys_out data, command table readback,
// busy flags and completion pulses against the queues filled by the testbench top
`timescale 1ns/100ps

module tb_ahci_dma_check
    import ahci_dma_pkg::*;
(
    input  logic       hclk,
    input  logic       hrst,
    input  logic       cmd_start,
    input  logic       arvalid,
    input  logic       arready,
    input  addr_t      araddr,
    input  burst_len_t arlen,
    input  axi_id_t    arid,
    input  cache_t     arcache,
    input  logic [2:0] arsize,
    input  logic [1:0] arburst,
    input  logic       rvalid,
    input  logic       rready,
    input  axi_id_t    rid,
    input  dword_t     sys_out,
    input  logic       sys_dav,
    input  logic       sys_re,
    input  logic       ct_re,
    input  ct_index_t  ct_addr,
    input  dword_t     ct_data,
    input  logic       ct_busy,
    input  logic       cmd_busy,
    input  logic       prd_done,
    input  logic       prd_irq,
    input  logic       cmd_done,
    input  int         tb_errors,      // timeouts seen by the top
    input  logic       report,
    output int         errors
);

    logic [41:0] exp_ar [$];           // {addr, len, id}
    dword_t      exp_data [$];
    logic        exp_irq [$];          // one per PRD still to finish
    dword_t      exp_ct [32];
    cache_t      exp_cache;
    int          exp_cmds = 0;
    int          errs = 0;
    int          queued_dw = 0;        // data dwords received, not yet popped
    int          ct_beats = 0;         // CT beats of the running command
    logic        after_rst;            // first cycle out of reset
    logic        exp_ct_busy;
    logic        exp_cmd_busy;
    logic        ct_pend;
    ct_index_t   ct_idx;
    logic [41:0] ar;
    logic        irq;

    assign errors = errs + tb_errors;

    task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            errs++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    always @(posedge hclk) begin
        if (hrst) begin
            ct_pend      <= 1'b0;
            after_rst    <= 1'b1;
            exp_ct_busy  <= 1'b0;
            exp_cmd_busy <= 1'b0;
        end else begin
            if (after_rst) begin
                compare("reset_flags", 32'd0,
                        {27'd0, arvalid, cmd_done, prd_done, prd_irq, sys_dav});
                compare("reset_arcache", {28'd0, CACHE_DEFAULT}, {28'd0, arcache});
            end
            after_rst <= 1'b0;
            compare("ct_busy", {31'd0, exp_ct_busy}, {31'd0, ct_busy});
            if (cmd_done) begin
                compare("cmd_busy", 32'd0, {31'd0, cmd_busy});     // falls with cmd_done
            end else begin
                compare("cmd_busy", {31'd0, exp_cmd_busy}, {31'd0, cmd_busy});
            end
            if (cmd_start) begin
                exp_ct_busy  <= 1'b1;
                exp_cmd_busy <= 1'b1;
                ct_beats = 0;
            end
            if (rvalid && rready && rid == ID_CT) begin
                ct_beats++;
                if (ct_beats == 16) begin
                    exp_ct_busy <= 1'b0;        // whole table fetched
                end
            end
            if (cmd_done) begin
                exp_cmd_busy <= 1'b0;
            end
            if (rvalid && !rready) begin
                errs++;
                $display("R beat refused with rready low");
            end
            if (arvalid && arready) begin
                if (exp_ar.size() == 0) begin
                    errs++;
                    $display("unexpected AR request to address %h", araddr);
                end else begin
                    ar = exp_ar.pop_front();
                    compare("ar_addr", ar[41:10], araddr);
                    compare("ar_len", {28'd0, ar[9:6]}, {28'd0, arlen});
                    compare("ar_id", {26'd0, ar[5:0]}, {26'd0, arid});
                    compare("ar_cache", {28'd0, exp_cache}, {28'd0, arcache});
                end
                compare("ar_size", 32'd3, {29'd0, arsize});         // 8-byte beats
                compare("ar_burst", 32'd1, {30'd0, arburst});       // INCR
                if (arid == ID_DATA && queued_dw > 32) begin
                    errs++;
                    $display("data AR issued with %0d dwords still queued", queued_dw);
                end
            end
            if (rvalid && rready && rid == ID_DATA) begin
                queued_dw += 2;
            end
            if (sys_dav && sys_re) begin
                queued_dw--;
                if (exp_data.size() == 0) begin
                    errs++;
                    $display("sys_out popped with no data expected");
                end else begin
                    compare("sys_data", exp_data.pop_front(), sys_out);
                end
            end
            if (ct_pend) begin
                compare("ct_readback", exp_ct[ct_idx], ct_data);   // one cycle after ct_re
            end
            ct_pend <= ct_re;
            ct_idx  <= ct_addr;
            if (prd_done) begin
                if (exp_irq.size() == 0) begin
                    errs++;
                    $display("prd_done pulsed with no PRD pending");
                end else begin
                    irq = exp_irq.pop_front();
                    compare("prd_irq", {31'd0, irq}, {31'd0, prd_irq});
                end
            end else if (prd_irq) begin
                errs++;
                $display("prd_irq pulsed without prd_done");
            end
            if (cmd_done) begin
                if (exp_cmds == 0) begin
                    errs++;
                    $display("cmd_done pulsed with no command running");
                end else begin
                    exp_cmds--;
                end
                if (exp_irq.size() != 0 || exp_data.size() != 0) begin
                    errs++;
                    $display("cmd_done with %0d PRDs and %0d dwords outstanding",
                             exp_irq.size(), exp_data.size());
                end
            end
        end
    end

    always @(posedge report) begin
        $display("checks done: %0d errors, %0d of them timeouts", errors, tb_errors);
    end

endmodule

//--- hw/ahci_dma.sv
// AHCI read DMA engine top
// command table, PRD and data fetch over one 64-bit AXI read channel
`timescale 1ns/100ps

module ahci_dma
    import ahci_dma_pkg::*;
(
    input  logic       hclk,
    input  logic       hrst,
    input  logic       cmd_start,
    input  addr_t      ctba,
    input  prd_count_t prdtl,
    input  ct_index_t  ct_addr,
    input  logic       ct_re,
    output dword_t     ct_data,
    output logic       ct_busy,
    output logic       cmd_busy,
    output logic       cmd_done,
    output logic       prd_done,
    output logic       prd_irq,
    output dword_t     sys_out,
    output logic       sys_dav,
    input  logic       sys_re,
    input  cache_t     cache_wr_data,
    input  logic       cache_we,
    output addr_t      araddr,
    output burst_len_t arlen,
    output axi_id_t    arid,
    output cache_t     arcache,
    output logic [2:0] arsize,
    output logic [1:0] arburst,
    output logic       arvalid,
    input  logic       arready,
    input  qword_t     rdata,
    input  logic       rvalid,
    input  logic       rlast,
    input  axi_id_t    rid,
    output logic       rready
);

    logic       req_valid;
    req_kind_t  req_kind;
    addr_t      req_addr;
    qw_count_t  req_qwords;
    logic       req_ready;
    logic       space_ok;
    cache_t     arcache_cfg;
    logic       data_burst_go;
    burst_len_t data_burst_len;
    logic       prd_qwords_go;
    qw_count_t  prd_qwords;
    logic       prd_last;
    logic       prd_drained;
    logic       cmd_drained;
    logic       data_beat;
    logic       ctl_beat;

    assign rready    = 1'b1;       // data space reserved before each AR
    assign arsize    = 3'd3;       // 8-byte beats
    assign arburst   = 2'b01;      // INCR
    assign data_beat = rvalid && rready && (rid == ID_DATA);
    assign ctl_beat  = rvalid && rready && (rid != ID_DATA);

    ahci_dma_cfg ahci_dma_cfg_i (.*, .arcache(arcache_cfg));

    ahci_dma_ctl ahci_dma_ctl_i (.*);

    ahci_dma_ar ahci_dma_ar_i (.*);

    ahci_dma_rd_fifo ahci_dma_rd_fifo_i (.*);

endmodule

//--- hw/ahci_dma_rd_fifo.sv
// AHCI DMA read data FIFO
// qword store with per-burst space reservation, dword output low half first,
// and drain reports per PRD and per command
`timescale 1ns/100ps

module ahci_dma_rd_fifo
    import ahci_dma_pkg::*;
(
    input  logic       hclk,
    input  logic       hrst,
    input  qword_t     rdata,
    input  logic       data_beat,
    input  logic       data_burst_go,
    input  burst_len_t data_burst_len,
    output logic       space_ok,
    input  logic       prd_qwords_go,
    input  qw_count_t  prd_qwords,
    input  logic       prd_last,
    output dword_t     sys_out,
    output logic       sys_dav,
    input  logic       sys_re,
    output logic       prd_drained,
    output logic       cmd_drained
);

    qword_t      mem [FIFO_QWORDS];
    logic [4:0]  wr_ptr;
    logic [4:0]  rd_ptr;
    logic        rd_half;       // high dword is next
    logic [5:0]  fill;          // qwords stored
    logic [5:0]  resv;          // qwords stored or still expected
    logic [19:0] dw_left;       // dwords of the current PRD not yet popped
    logic        last_prd;
    logic        pop;
    logic        qw_pop;

    assign sys_dav  = (fill != '0);
    assign pop      = sys_re && sys_dav;
    assign qw_pop   = pop && rd_half;                   // qword fully read
    assign sys_out  = rd_half ? mem[rd_ptr][63:32] : mem[rd_ptr][31:0];
    assign space_ok = (resv <= 6'(FIFO_QWORDS - MAX_BURST_LEN - 1));

    assign prd_drained = pop && (dw_left == 20'd1);
    assign cmd_drained = prd_drained && last_prd;

    always_ff @(posedge hclk) begin
        if (data_beat) begin
            mem[wr_ptr] <= rdata;
        end
        if (prd_qwords_go) begin
            last_prd <= prd_last;
        end
    end

    always_ff @(posedge hclk) begin
        if (hrst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            rd_half <= 1'b0;
            fill    <= '0;
            resv    <= '0;
            dw_left <= '0;
        end else begin
            if (data_beat) begin
                wr_ptr <= wr_ptr + 5'd1;
            end
            if (pop) begin
                rd_half <= !rd_half;
            end
            if (qw_pop) begin
                rd_ptr <= rd_ptr + 5'd1;
            end
            fill <= fill + {5'd0, data_beat} - {5'd0, qw_pop};
            resv <= resv + (data_burst_go ? {2'd0, data_burst_len} + 6'd1 : 6'd0)
                         - {5'd0, qw_pop};
            if (prd_qwords_go) begin
                dw_left <= {prd_qwords, 1'b0};          // two dwords per qword
            end else if (pop) begin
                dw_left <= dw_left - 20'd1;
            end
        end
    end

endmodule

//--- hw/ahci_dma_ar.sv
// AHCI DMA read address generator
// turns CT, PRD and data requests into AXI AR bursts, one outstanding,
// data split at 16 qwords and issued only while the FIFO has room
`timescale 1ns/100ps

module ahci_dma_ar
    import ahci_dma_pkg::*;
(
    input  logic       hclk,
    input  logic       hrst,
    input  logic       req_valid,
    input  req_kind_t  req_kind,
    input  addr_t      req_addr,
    input  qw_count_t  req_qwords,
    output logic       req_ready,
    input  logic       space_ok,        // room for a full data burst
    input  cache_t     arcache_cfg,
    output addr_t      araddr,
    output burst_len_t arlen,
    output axi_id_t    arid,
    output cache_t     arcache,
    output logic       arvalid,
    input  logic       arready,
    input  logic       rvalid,
    input  logic       rready,
    input  logic       rlast,
    output logic       data_burst_go,
    output burst_len_t data_burst_len
);

    req_kind_t kind;
    addr_t     cur_addr;
    qw_count_t left;            // data qwords not yet requested
    logic      busy;            // request held, bursts still to issue
    logic      outstanding;     // AR sent, rlast not seen yet
    logic      last_burst;
    logic      issue;
    logic      ar_take;

    assign req_ready  = !busy;
    assign last_burst = (kind != kind_data) || (left <= 19'd16);
    assign issue      = busy && !arvalid && !outstanding &&
                        (kind != kind_data || space_ok);
    assign ar_take    = arvalid && arready;

    // FIFO reserves space when a data burst is accepted
    assign data_burst_go  = ar_take && (arid == ID_DATA);
    assign data_burst_len = arlen;

    always_ff @(posedge hclk) begin
        if (hrst) begin
            busy        <= 1'b0;
            outstanding <= 1'b0;
            arvalid     <= 1'b0;
            arcache     <= CACHE_DEFAULT;
        end else begin
            if (req_valid && req_ready) begin
                busy <= 1'b1;
            end else if (ar_take && last_burst) begin
                busy <= 1'b0;
            end
            if (issue) begin
                arvalid <= 1'b1;
                arcache <= arcache_cfg;                 // cache mode per request
            end else if (ar_take) begin
                arvalid <= 1'b0;                        // held until arready
            end
            if (ar_take) begin
                outstanding <= 1'b1;
            end else if (rvalid && rready && rlast) begin
                outstanding <= 1'b0;
            end
        end
    end

    always_ff @(posedge hclk) begin
        if (req_valid && req_ready) begin
            kind     <= req_kind;
            cur_addr <= req_addr;
            left     <= req_qwords;
        end else if (ar_take) begin
            cur_addr <= cur_addr + 32'd128;             // next 16-qword block
            left     <= left - 19'd16;
        end
        if (issue) begin
            araddr <= cur_addr;
            case (kind)
                kind_ct: begin
                    arlen <= CT_BURST_LEN;
                    arid  <= ID_CT;
                end
                kind_prd: begin
                    arlen <= PRD_BURST_LEN;
                    arid  <= ID_PRD;
                end
                default: begin
                    // short tail burst, left is 1..16 here
                    arlen <= last_burst ? left[3:0] - 4'd1 : MAX_BURST_LEN;
                    arid  <= ID_DATA;
                end
            endcase
        end
    end

endmodule

//--- hw/ahci_dma_ctl.sv
// AHCI DMA command sequencer
// fetches the command table into a dword store, walks the PRD table,
// decodes each entry and hands the data region to the AR generator and FIFO
`timescale 1ns/100ps

module ahci_dma_ctl
    import ahci_dma_pkg::*;
(
    input  logic       hclk,
    input  logic       hrst,
    input  logic       cmd_start,
    input  addr_t      ctba,          // low 7 bits ignored
    input  prd_count_t prdtl,
    input  ct_index_t  ct_addr,
    input  logic       ct_re,
    output dword_t     ct_data,
    output logic       ct_busy,
    output logic       cmd_busy,
    output logic       cmd_done,
    output logic       prd_done,
    output logic       prd_irq,
    output logic       req_valid,
    output req_kind_t  req_kind,
    output addr_t      req_addr,
    output qw_count_t  req_qwords,
    input  logic       req_ready,
    input  qword_t     rdata,
    input  logic       ctl_beat,      // R beat with a CT or PRD id
    input  logic       rlast,
    output logic       prd_qwords_go,
    output qw_count_t  prd_qwords,
    output logic       prd_last,
    input  logic       prd_drained,
    input  logic       cmd_drained
);

    dma_state_t state;
    dword_t     ct_mem [32];
    addr_t      ct_base;       // 128-byte aligned table base
    addr_t      prd_addr;      // next PRD entry
    addr_t      data_addr;     // region of current PRD
    qw_count_t  xfer_qwords;
    logic       xfer_irq;      // current PRD asks for an interrupt
    prd_count_t prds_left;     // entries not yet fetched
    logic [3:0] beat_idx;      // beat within the current CT/PRD burst
    logic       ct_done_r;
    logic       req_take;
    logic       ctl_last;
    logic       done_w;

    assign req_take = req_valid && req_ready;
    assign ctl_last = ctl_beat && rlast;
    // last PRD drained, or no PRDs at all
    assign done_w   = cmd_drained || (ct_done_r && prds_left == '0);

    always_comb begin
        req_kind = kind_data;
        req_addr = data_addr;
        if (state == st_ct) begin
            req_kind = kind_ct;
            req_addr = ct_base;
        end else if (state == st_prd) begin
            req_kind = kind_prd;
            req_addr = prd_addr;
        end
    end

    assign req_qwords    = xfer_qwords;     // ignored for CT and PRD
    assign prd_qwords    = xfer_qwords;
    assign prd_qwords_go = (state == st_data) && req_take;
    assign prd_last      = (prds_left == '0);   // already decremented

    // command table store and PRD fields
    always_ff @(posedge hclk) begin
        if (ct_re) begin
            ct_data <= ct_mem[ct_addr];
        end
        if (ctl_beat && state == st_ct) begin
            ct_mem[{beat_idx, 1'b0}] <= rdata[31:0];    // low dword first
            ct_mem[{beat_idx, 1'b1}] <= rdata[63:32];
        end
        if (ctl_beat && state == st_prd) begin
            if (!beat_idx[0]) begin
                data_addr <= {rdata[31:3], 3'b000};     // qword aligned
            end else begin
                xfer_qwords <= rdata[32 + PRD_DBC_MSB : 35] + 19'd1;
                xfer_irq    <= rdata[32 + PRD_IRQ_BIT];
            end
        end
        if (state == st_idle && cmd_start) begin
            ct_base  <= {ctba[31:7], 7'd0};
            prd_addr <= {ctba[31:7], 7'd0} + PRDT_OFFSET;
        end else if (state == st_prd && ctl_last) begin
            prd_addr <= prd_addr + 32'd16;              // 16-byte entries
        end
    end

    always_ff @(posedge hclk) begin
        if (hrst) begin
            state     <= st_idle;
            req_valid <= 1'b0;
            ct_busy   <= 1'b0;
            cmd_busy  <= 1'b0;
            cmd_done  <= 1'b0;
            prd_done  <= 1'b0;
            prd_irq   <= 1'b0;
            ct_done_r <= 1'b0;
            beat_idx  <= '0;
            prds_left <= '0;
        end else begin
            prd_done  <= prd_drained;
            prd_irq   <= prd_drained && xfer_irq;
            cmd_done  <= done_w;
            ct_done_r <= 1'b0;
            if (req_take) begin
                req_valid <= 1'b0;
                beat_idx  <= '0;
            end else if (ctl_beat) begin
                beat_idx <= beat_idx + 4'd1;
            end
            if (done_w) begin
                cmd_busy <= 1'b0;                       // falls with cmd_done
            end
            case (state)
                st_idle: begin
                    if (cmd_start) begin
                        state     <= st_ct;
                        req_valid <= 1'b1;
                        ct_busy   <= 1'b1;
                        cmd_busy  <= 1'b1;
                        prds_left <= prdtl;
                    end
                end
                st_ct: begin
                    if (ctl_last) begin
                        ct_busy   <= 1'b0;
                        ct_done_r <= 1'b1;
                        if (prds_left == '0) begin
                            state <= st_drain;          // only cmd_done left
                        end else begin
                            state     <= st_prd;
                            req_valid <= 1'b1;
                        end
                    end
                end
                st_prd: begin
                    if (ctl_last) begin
                        state     <= st_data;
                        req_valid <= 1'b1;
                        prds_left <= prds_left - 16'd1;
                    end
                end
                st_data: begin
                    if (req_take) begin
                        state <= st_drain;
                    end
                end
                st_drain: begin
                    if (done_w) begin
                        state <= st_idle;
                    end else if (prd_drained) begin
                        state     <= st_prd;            // next entry
                        req_valid <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- hw/ahci_dma_cfg.sv
// AHCI DMA configuration register
// holds the AXI read cache mode
`timescale 1ns/100ps

module ahci_dma_cfg
    import ahci_dma_pkg::*;
(
    input  logic   hclk,
    input  logic   hrst,
    input  cache_t cache_wr_data,
    input  logic   cache_we,
    output cache_t arcache        // sampled by the AR generator per request
);

    always_ff @(posedge hclk) begin
        if (hrst) begin
            arcache <= CACHE_DEFAULT;
        end else if (cache_we) begin
            arcache <= cache_wr_data;
        end
    end

endmodule

//--- hw/ahci_dma_pkg.sv
// AHCI read DMA shared definitions
// widths, PRD field positions, burst constants and FSM encodings
package ahci_dma_pkg;

    typedef logic [31:0] addr_t;       // system memory byte address
    typedef logic [63:0] qword_t;      // AXI data beat
    typedef logic [31:0] dword_t;      // host side word
    typedef logic [4:0]  ct_index_t;   // command table dword index
    typedef logic [15:0] prd_count_t;  // number of PRD entries
    typedef logic [18:0] qw_count_t;   // qwords in one PRD
    typedef logic [3:0]  burst_len_t;  // AXI len, beats minus one
    typedef logic [3:0]  cache_t;      // AXI cache mode
    typedef logic [5:0]  axi_id_t;

    localparam burst_len_t CT_BURST_LEN  = 4'd15;   // 16 qwords, 128 bytes
    localparam burst_len_t PRD_BURST_LEN = 4'd1;    // one 16-byte entry
    localparam burst_len_t MAX_BURST_LEN = 4'd15;
    localparam addr_t      PRDT_OFFSET   = 32'h80;
    localparam cache_t     CACHE_DEFAULT = 4'h3;

    localparam axi_id_t    ID_CT   = 6'd0;
    localparam axi_id_t    ID_PRD  = 6'd1;
    localparam axi_id_t    ID_DATA = 6'd2;

    localparam int         FIFO_QWORDS = 32;
    localparam int         PRD_IRQ_BIT = 31;        // in PRD dword 3
    localparam int         PRD_DBC_MSB = 21;        // byte count minus one

    typedef enum logic [2:0] {
        st_idle, st_ct, st_prd, st_data, st_drain
    } dma_state_t;

    // request class from the sequencer to the address generator
    typedef enum logic [1:0] {
        kind_ct, kind_prd, kind_data
    } req_kind_t;

endpackage
